//--- hdl/noc_pkg.sv
package noc_pkg;

	// Ring size and packet budget
	localparam int NODES = 4;
	localparam int NODE_W = 2;
	localparam int PKTS_PER_NODE = 32;

	// Field and counter widths
	localparam int SEQ_W = 8;
	localparam int DATA_W = 16;
	localparam int CNT_W = 16;

	// Single-flit packet, 28 bits in all
	typedef struct packed {
		logic [NODE_W-1:0] src;
		logic [NODE_W-1:0] dst;
		logic [SEQ_W-1:0]  seq;
		logic [DATA_W-1:0] data;
	} flit_t;

	// Destination of packet seq from node src
	// Walks the other nodes in turn, never src itself
	function automatic logic [NODE_W-1:0] flit_dst(input logic [NODE_W-1:0] src,
			input logic [SEQ_W-1:0] seq);
		int offset;
		offset = 1 + (int'(seq) % (NODES - 1));
		return NODE_W'((int'(src) + offset) % NODES);
	endfunction

	// Expected payload for a packet
	// High byte mixes src and dst, low byte carries seq
	function automatic logic [DATA_W-1:0] flit_payload(input logic [NODE_W-1:0] src,
			input logic [NODE_W-1:0] dst, input logic [SEQ_W-1:0] seq);
		logic [7:0] mix;
		mix = {4'(src), 4'(dst)} ^ 8'hc3;
		return DATA_W'({mix, seq[7:0]});
	endfunction

endpackage

//--- hdl/ring_link_if.sv
`timescale 1ns/100ps

// One hop of the ring, router i to router i+1
interface ring_link_if;

	// Strobe, flit is taken in the cycle valid is high
	logic valid;
	noc_pkg::flit_t flit;

	// Upstream router drives the link
	modport tx (
		output valid,
		output flit
	);

	// Downstream router only looks
	modport rx (
		input valid,
		input flit
	);

endinterface

//--- hdl/reset_sync.sv
`timescale 1ns/100ps

module reset_sync (
	input  logic clk,
	input  logic reset_in,
	output logic reset_out
);

	// First stage, may go metastable on release
	logic meta;

	// Assert at once, release on the second edge after reset_in falls
	always_ff @(posedge clk or posedge reset_in) begin
		if (reset_in) begin
			meta <= 1'b1;
			reset_out <= 1'b1;
		end else begin
			meta <= 1'b0;
			reset_out <= meta;
		end
	end

endmodule

//--- hdl/traffic_injector.sv
`timescale 1ns/100ps

module traffic_injector #(
	parameter int NODE_ID = 0
) (
	input  logic           clk,
	input  logic           reset,
	output logic           inj_valid,
	output noc_pkg::flit_t inj_flit,
	input  logic           inj_accept,
	output logic           sent_all
);

	localparam logic [noc_pkg::NODE_W-1:0] SRC = noc_pkg::NODE_W'(NODE_ID);
	localparam logic [noc_pkg::SEQ_W-1:0] LAST_SEQ = noc_pkg::SEQ_W'(noc_pkg::PKTS_PER_NODE - 1);

	// Running packet number over all destinations
	logic [noc_pkg::SEQ_W-1:0] seq;
	logic [noc_pkg::NODE_W-1:0] dst;
	logic take;

	// Handshake completes on this edge
	assign take = inj_valid && inj_accept;

	// Current packet, built from the seq counter
	assign dst = noc_pkg::flit_dst(SRC, seq);

	always_comb begin
		inj_flit.src = SRC;
		inj_flit.dst = dst;
		inj_flit.seq = seq;
		inj_flit.data = noc_pkg::flit_payload(SRC, dst, seq);
	end

	// Offer starts one cycle after reset release
	// Flit held until the router accepts it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			seq <= '0;
			inj_valid <= 1'b0;
			sent_all <= 1'b0;
		end else begin
			if (!inj_valid && !sent_all) begin
				inj_valid <= 1'b1;
			end
			if (take) begin
				seq <= seq + 1'b1;
				// Last packet gone, stop offering
				if (seq == LAST_SEQ) begin
					inj_valid <= 1'b0;
					sent_all <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/ring_router.sv
`timescale 1ns/100ps

module ring_router #(
	parameter int NODE_ID = 0
) (
	input  logic           clk,
	input  logic           reset,
	ring_link_if.rx        link_in,
	ring_link_if.tx        link_out,
	input  logic           inj_valid,
	input  noc_pkg::flit_t inj_flit,
	output logic           inj_accept,
	output logic           ej_valid,
	output noc_pkg::flit_t ej_flit
);

	localparam logic [noc_pkg::NODE_W-1:0] SELF = noc_pkg::NODE_W'(NODE_ID);

	// Incoming flit has reached its destination
	logic eject_hit;
	// Incoming flit keeps going round the ring
	logic pass_valid;
	// Local flit goes into the free slot
	logic take_local;

	assign eject_hit = link_in.valid && (link_in.flit.dst == SELF);
	assign pass_valid = link_in.valid && !eject_hit;

	// Ejection is combinational, the sink registers it
	assign ej_valid = eject_hit;
	assign ej_flit = link_in.flit;

	// Slot is free when nothing passes through
	// Ring traffic always wins
	assign inj_accept = !pass_valid;
	assign take_local = inj_valid && inj_accept;

	// Outgoing slot, one hop per cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			link_out.valid <= 1'b0;
		end else begin
			link_out.valid <= pass_valid || take_local;
		end
	end

	// Flit payload, follows the valid
	always_ff @(posedge clk) begin
		if (pass_valid) begin
			link_out.flit <= link_in.flit;
		end else if (take_local) begin
			link_out.flit <= inj_flit;
		end
	end

endmodule

//--- hdl/traffic_sink.sv
`timescale 1ns/100ps

module traffic_sink #(
	parameter int NODE_ID = 0
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      ej_valid,
	input  noc_pkg::flit_t            ej_flit,
	output logic [noc_pkg::CNT_W-1:0] rx_count,
	output logic                      rx_all,
	output logic                      error
);

	localparam logic [noc_pkg::NODE_W-1:0] SELF = noc_pkg::NODE_W'(NODE_ID);

	// Packets addressed to this node over the whole run
	function automatic int rx_expected(input int node);
		int total;
		total = 0;
		for (int s = 0; s < noc_pkg::NODES; s++) begin
			for (int q = 0; q < noc_pkg::PKTS_PER_NODE; q++) begin
				if (s != node && noc_pkg::flit_dst(noc_pkg::NODE_W'(s),
						noc_pkg::SEQ_W'(q)) == noc_pkg::NODE_W'(node)) begin
					total++;
				end
			end
		end
		return total;
	endfunction

	// Next seq from src that lands here, searching after seq
	function automatic logic [noc_pkg::SEQ_W-1:0] next_seq(input logic [noc_pkg::NODE_W-1:0] src,
			input logic [noc_pkg::SEQ_W-1:0] seq);
		logic [noc_pkg::SEQ_W-1:0] cand;
		logic found;
		cand = seq;
		found = 1'b0;
		for (int k = 1; k < noc_pkg::NODES; k++) begin
			if (!found && noc_pkg::flit_dst(src, seq + noc_pkg::SEQ_W'(k)) == SELF) begin
				cand = seq + noc_pkg::SEQ_W'(k);
				found = 1'b1;
			end
		end
		return cand;
	endfunction

	localparam int EXP_COUNT = rx_expected(NODE_ID);

	// Input register for the ejected flit
	logic rx_valid;
	noc_pkg::flit_t rx_flit;
	// Next expected seq per source
	logic [noc_pkg::SEQ_W-1:0] exp_seq [noc_pkg::NODES];
	logic bad;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= ej_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ej_valid) begin
			rx_flit <= ej_flit;
		end
	end

	// Wrong node, out of order, or corrupted data
	assign bad = (rx_flit.dst != SELF) || (rx_flit.seq != exp_seq[rx_flit.src]) ||
		(rx_flit.data != noc_pkg::flit_payload(rx_flit.src, rx_flit.dst, rx_flit.seq));

	// Count, step the order tracker, latch any error
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_count <= '0;
			error <= 1'b0;
			// Search from all ones wraps round to seq 0
			for (int s = 0; s < noc_pkg::NODES; s++) begin
				exp_seq[s] <= next_seq(noc_pkg::NODE_W'(s), '1);
			end
		end else if (rx_valid) begin
			rx_count <= rx_count + 1'b1;
			exp_seq[rx_flit.src] <= next_seq(rx_flit.src, rx_flit.seq);
			if (bad) begin
				error <= 1'b1;
			end
		end
	end

	assign rx_all = (rx_count == noc_pkg::CNT_W'(EXP_COUNT));

endmodule

//--- hdl/noc_emulator.sv
`timescale 1ns/100ps

module noc_emulator (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      injector_reset,
	output logic                      done,
	output logic [noc_pkg::CNT_W-1:0] rx_total,
	output logic                      error
);

	// Link i runs from router i to router i+1
	ring_link_if link [noc_pkg::NODES] ();

	// Per-node status
	logic [noc_pkg::NODES-1:0] sent_all;
	logic [noc_pkg::NODES-1:0] rx_all;
	logic [noc_pkg::NODES-1:0] sink_err;
	logic [noc_pkg::CNT_W-1:0] rx_count [noc_pkg::NODES];
	logic [noc_pkg::CNT_W-1:0] count_sum;

	genvar i;
	generate
		for (i = 0; i < noc_pkg::NODES; i++) begin : g_node
			logic inj_valid;
			logic inj_accept;
			logic ej_valid;
			noc_pkg::flit_t inj_flit;
			noc_pkg::flit_t ej_flit;

			// Router takes the link from its upstream neighbour
			ring_router #(.NODE_ID(i)) u_router (
				.clk        (clk),
				.reset      (reset),
				.link_in    (link[(i + noc_pkg::NODES - 1) % noc_pkg::NODES]),
				.link_out   (link[i]),
				.inj_valid  (inj_valid),
				.inj_flit   (inj_flit),
				.inj_accept (inj_accept),
				.ej_valid   (ej_valid),
				.ej_flit    (ej_flit)
			);

			// Traffic ends run off the injector reset
			traffic_injector #(.NODE_ID(i)) u_injector (
				.clk        (clk),
				.reset      (injector_reset),
				.inj_valid  (inj_valid),
				.inj_flit   (inj_flit),
				.inj_accept (inj_accept),
				.sent_all   (sent_all[i])
			);

			traffic_sink #(.NODE_ID(i)) u_sink (
				.clk        (clk),
				.reset      (injector_reset),
				.ej_valid   (ej_valid),
				.ej_flit    (ej_flit),
				.rx_count   (rx_count[i]),
				.rx_all     (rx_all[i]),
				.error      (sink_err[i])
			);
		end
	endgenerate

	always_comb begin
		count_sum = '0;
		for (int n = 0; n < noc_pkg::NODES; n++) begin
			count_sum = count_sum + rx_count[n];
		end
	end

	// Run status, registered for the top
	always_ff @(posedge clk or posedge injector_reset) begin
		if (injector_reset) begin
			done <= 1'b0;
			rx_total <= '0;
			error <= 1'b0;
		end else begin
			done <= (&sent_all) && (&rx_all);
			rx_total <= count_sum;
			error <= |sink_err;
		end
	end

endmodule

//--- hdl/emulator_top.sv
`timescale 1ns/100ps

module emulator_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      reset_noc_req,
	input  logic                      reset_injector_req,
	output logic                      done,
	output logic [31:0]               time_cnt,
	output logic [noc_pkg::CNT_W-1:0] rx_total,
	output logic                      error
);

	logic reset_noc_raw;
	logic reset_injector_raw;
	logic reset_noc_sync;
	logic reset_injector_sync;

	// Network reset also resets the injectors
	assign reset_noc_raw = reset | reset_noc_req;
	assign reset_injector_raw = reset_noc_raw | reset_injector_req;

	reset_sync u_noc_rst_sync (
		.clk       (clk),
		.reset_in  (reset_noc_raw),
		.reset_out (reset_noc_sync)
	);

	reset_sync u_injector_rst_sync (
		.clk       (clk),
		.reset_in  (reset_injector_raw),
		.reset_out (reset_injector_sync)
	);

	noc_emulator u_emulator (
		.clk            (clk),
		.reset          (reset_noc_sync),
		.injector_reset (reset_injector_sync),
		.done           (done),
		.rx_total       (rx_total),
		.error          (error)
	);

	// Run length in cycles, holds once done
	always_ff @(posedge clk or posedge reset_injector_sync) begin
		if (reset_injector_sync) begin
			time_cnt <= '0;
		end else if (!done) begin
			time_cnt <= time_cnt + 32'd1;
		end
	end

endmodule

//--- tb/tb_emulator_top.sv
`timescale 1ns/100ps

module tb_emulator_top;

	// Upper bound on any single wait, in clock cycles
	localparam int TIMEOUT_CYCLES = 2000;
	// Cycles that time_cnt must hold after done
	localparam int HOLD_CYCLES = 20;

	logic clk;
	logic reset;
	logic reset_noc_req;
	logic reset_injector_req;
	logic done;
	logic [31:0] time_cnt;
	logic [noc_pkg::CNT_W-1:0] rx_total;
	logic error;

	int errors;
	int checks;
	logic timed_out;
	logic [31:0] lcg_state;
	int run_cycles;
	int expected_total;

	emulator_top u_dut (
		.clk                (clk),
		.reset              (reset),
		.reset_noc_req      (reset_noc_req),
		.reset_injector_req (reset_injector_req),
		.done               (done),
		.time_cnt           (time_cnt),
		.rx_total           (rx_total),
		.error              (error)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// Destination of packet seq from src, other nodes taken in turn
	function automatic int ref_dst(input int src, input int seq);
		return (src + 1 + (seq % (noc_pkg::NODES - 1))) % noc_pkg::NODES;
	endfunction

	// Packets addressed to one node over a whole run
	function automatic int ref_count(input int node);
		int total;
		total = 0;
		for (int s = 0; s < noc_pkg::NODES; s++) begin
			for (int q = 0; q < noc_pkg::PKTS_PER_NODE; q++) begin
				if (ref_dst(s, q) == node) begin
					total++;
				end
			end
		end
		return total;
	endfunction

	// Sum over all sinks
	function automatic int ref_total();
		int total;
		total = 0;
		for (int d = 0; d < noc_pkg::NODES; d++) begin
			total += ref_count(d);
		end
		return total;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	// Sink error flag must never rise
	always @(negedge clk) begin
		compare("error", 32'd0, 32'(error));
	end

	task automatic check_zero_state();
		compare("done", 32'd0, 32'(done));
		compare("error", 32'd0, 32'(error));
		compare("time_cnt", 32'd0, time_cnt);
		compare("rx_total", 32'd0, 32'(rx_total));
	endtask

	// Wait for done, sampled on the falling edge
	task automatic wait_done(output int cycles);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT_CYCLES) begin
			@(posedge clk);
			n++;
			@(negedge clk);
			seen = done;
		end
		cycles = n;
		if (!seen) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: done did not rise within %0d cycles", TIMEOUT_CYCLES);
		end
	endtask

	// One-cycle request pulse, then a look at the cleared state
	task automatic pulse_request(input logic noc);
		@(posedge clk);
		if (noc) begin
			reset_noc_req <= 1'b1;
		end else begin
			reset_injector_req <= 1'b1;
		end
		@(posedge clk);
		reset_noc_req <= 1'b0;
		reset_injector_req <= 1'b0;
		@(negedge clk);
		check_zero_state();
	endtask

	// Counter bounds, then it must hold while done stays high
	task automatic check_counter(input int cycles);
		logic [31:0] held;
		held = time_cnt;
		if (int'(held) < noc_pkg::PKTS_PER_NODE) begin
			errors++;
			$display("ERROR at %0t: time_cnt expected at least %0d, got %0d", $time,
				noc_pkg::PKTS_PER_NODE, held);
		end
		if (int'(held) > cycles) begin
			errors++;
			$display("ERROR at %0t: time_cnt expected at most %0d, got %0d", $time,
				cycles, held);
		end
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			compare("time_cnt", held, time_cnt);
			compare("done", 32'd1, 32'(done));
		end
	endtask

	task automatic finish_check();
		compare("rx_total", 32'(expected_total), 32'(rx_total));
		compare("error", 32'd0, 32'(error));
	endtask

	// Cut a fresh run short with a network reset, then let it finish
	task automatic noc_reset_mid_run();
		int cut;
		int n;
		int cycles;
		pulse_request(1'b1);
		lcg_state = lcg_next(lcg_state);
		cut = 4 + int'((lcg_state >> 16) % 32'd24);
		n = 0;
		while (n < cut && !done) begin
			@(posedge clk);
			n++;
			@(negedge clk);
		end
		if (done) begin
			errors++;
			$display("done rose before the mid-run network reset at cycle %0d", cut);
		end
		// Counter starts two edges after release
		compare("time_cnt", 32'(n - 2), time_cnt);
		pulse_request(1'b1);
		wait_done(cycles);
		if (!timed_out) begin
			finish_check();
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		reset_noc_req = 1'b0;
		reset_injector_req = 1'b0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		lcg_state = 32'd93082;
		expected_total = ref_total();

		// Reset state while held
		@(negedge clk);
		check_zero_state();
		// Second rising edge with reset high, then release
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_zero_state();

		// First full run
		wait_done(run_cycles);
		if (!timed_out) begin
			finish_check();
			check_counter(run_cycles);
		end

		// Injector-only rerun on an empty ring
		if (!timed_out) begin
			pulse_request(1'b0);
			wait_done(run_cycles);
			if (!timed_out) begin
				finish_check();
			end
		end

		if (!timed_out) begin
			noc_reset_mid_run();
		end

		$display("Run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
hdl/noc_pkg.sv
hdl/ring_link_if.sv
hdl/reset_sync.sv
hdl/traffic_injector.sv
hdl/ring_router.sv
hdl/traffic_sink.sv
hdl/noc_emulator.sv
hdl/emulator_top.sv
tb/tb_emulator_top.sv

//--- Makefile
# Verilator build and run of the NoC emulator testbench

VERILATOR ?= verilator
TOP       ?= tb_emulator_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
